//--- common/ls_pkg.sv
package ls_pkg;

    // data and address width, fixed by the 8-bit byte mask.
    localparam int XLEN     = 64;
    localparam int INST_LEN = 32;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // access size in bits [1:0] as log2 of the byte count, bit 2 set for zero extension.
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // environment call from machine mode.
    localparam logic [XLEN-1:0] MCAUSE_TRAP = 64'd11;

    typedef logic [2:0] mem_size_t;

    // the same 32-bit word seen as a load/store and as a CSR instruction.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } mem;
        struct packed {
            logic [11:0] csr_addr;
            logic [4:0]  rs1_uimm;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } csr;
    } instr_u;

endpackage

//--- ls_stage/ls_ctrl.sv
module ls_ctrl (
    input  ls_pkg::instr_u              instr_i,
    input  ls_pkg::instr_u              instr_last_i,
    input  logic [ls_pkg::XLEN-1:0]     rs2_i,
    input  logic [ls_pkg::XLEN-1:0]     wb_data_i,
    output logic                        wr_en_o,
    output logic                        rd_en_o,
    output ls_pkg::mem_size_t           mem_op_o,
    output logic [ls_pkg::XLEN-1:0]     wr_data_o
);
    import ls_pkg::*;

    logic is_load;
    logic is_store;
    logic size_ok_ld;
    logic size_ok_st;
    logic last_writes_rd;
    logic fwd_hit;

    assign is_load  = (instr_i.mem.opcode == OPC_LOAD);
    assign is_store = (instr_i.mem.opcode == OPC_STORE);

    // stores have no unsigned forms, and 3'b111 is not a valid size.
    always_comb begin
        size_ok_ld = 1'b0;
        size_ok_st = 1'b0;
        case (instr_i.mem.funct3)
            F3_B, F3_H, F3_W, F3_D: begin
                size_ok_ld = 1'b1;
                size_ok_st = 1'b1;
            end
            F3_BU, F3_HU, F3_WU: begin
                size_ok_ld = 1'b1;
            end
            default: begin
                size_ok_ld = 1'b0;
            end
        endcase
    end

    assign rd_en_o  = is_load && size_ok_ld;
    assign wr_en_o  = is_store && size_ok_st;
    assign mem_op_o = instr_i.mem.funct3;

    // stores and branches carry immediate bits where rd would be.
    assign last_writes_rd = (instr_last_i.mem.opcode != OPC_STORE) &&
                            (instr_last_i.mem.opcode != OPC_BRANCH) &&
                            (instr_last_i.mem.rd != 5'd0);

    assign fwd_hit = last_writes_rd && (instr_last_i.mem.rd == instr_i.mem.rs2);

    // the register file has not seen the previous result yet.
    assign wr_data_o = fwd_hit ? wb_data_i : rs2_i;

endmodule

//--- ls_stage/lsu.sv
module lsu (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        wr_en_i,
    input  logic                        rd_en_i,
    input  ls_pkg::mem_size_t           mem_op_i,
    input  logic [ls_pkg::XLEN-1:0]     wr_data_i,
    input  logic [ls_pkg::XLEN-1:0]     addr_i,
    input  logic                        ls_sram_rd_data_valid_i,
    input  logic                        ls_sram_wr_data_ok_i,
    input  logic [ls_pkg::XLEN-1:0]     ls_sram_rd_data_i,
    output logic [ls_pkg::XLEN-1:0]     ls_res_o,
    output logic                        ls_busy_o,
    output logic [ls_pkg::XLEN-1:0]     ls_sram_addr_o,
    output logic                        ls_sram_rd_en_o,
    output logic                        ls_sram_wr_en_o,
    output logic [ls_pkg::XLEN-1:0]     ls_sram_wr_data_o,
    output logic [7:0]                  ls_sram_wr_mask_o,
    output ls_pkg::mem_size_t           ls_sram_wr_size_o,
    output ls_pkg::mem_size_t           ls_sram_rd_size_o
);
    import ls_pkg::*;

    localparam logic IDLE = 1'b0;
    localparam logic WAIT = 1'b1;

    logic               state_q;
    logic               rd_q;
    logic               wr_q;
    logic               req;
    logic               ack;
    logic [2:0]         offset;
    logic [2:0]         align_mask;
    logic [7:0]         base_mask;
    logic [XLEN-1:0]    addr_q;
    logic [XLEN-1:0]    wr_data_q;
    logic [7:0]         wr_mask_q;
    mem_size_t          size_q;
    logic [XLEN-1:0]    rd_shifted;
    logic [XLEN-1:0]    load_val;
    logic [XLEN-1:0]    ls_res_q;

    assign req = (state_q == IDLE) && (rd_en_i || wr_en_i);
    assign ack = (state_q == WAIT) &&
                 ((rd_q && ls_sram_rd_data_valid_i) || (wr_q && ls_sram_wr_data_ok_i));

    assign offset     = addr_i[2:0];
    assign align_mask = 3'((4'd1 << mem_op_i[1:0]) - 4'd1);

    always_comb begin
        case (mem_op_i[1:0])
            2'b00:   base_mask = 8'h01;
            2'b01:   base_mask = 8'h03;
            2'b10:   base_mask = 8'h0f;
            default: base_mask = 8'hff;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            rd_q    <= 1'b0;
            wr_q    <= 1'b0;
        end else if (req) begin
            state_q <= WAIT;
            rd_q    <= rd_en_i;
            wr_q    <= wr_en_i;
        end else if (ack) begin
            state_q <= IDLE;   // enable drops in the cycle after the answer.
        end
    end

    // the request is captured once and held until the SRAM answers.
    always_ff @(posedge clk) begin
        if (req) begin
            addr_q    <= addr_i;
            size_q    <= mem_op_i;
            wr_data_q <= wr_data_i << {offset, 3'b000};
            wr_mask_q <= base_mask << offset;
        end
        if (ack && rd_q) begin
            ls_res_q <= load_val;
        end
    end

    assign rd_shifted = ls_sram_rd_data_i >> {addr_q[2:0], 3'b000};

    always_comb begin
        case (size_q)
            F3_B:    load_val = {{(XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
            F3_H:    load_val = {{(XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
            F3_W:    load_val = {{(XLEN-32){rd_shifted[31]}}, rd_shifted[31:0]};
            F3_BU:   load_val = {{(XLEN-8){1'b0}}, rd_shifted[7:0]};
            F3_HU:   load_val = {{(XLEN-16){1'b0}}, rd_shifted[15:0]};
            F3_WU:   load_val = {{(XLEN-32){1'b0}}, rd_shifted[31:0]};
            default: load_val = rd_shifted;
        endcase
    end

    assign ls_res_o  = (ack && rd_q) ? load_val : ls_res_q;
    assign ls_busy_o = req || ((state_q == WAIT) && !ack);

    assign ls_sram_addr_o    = addr_q;
    assign ls_sram_rd_en_o   = (state_q == WAIT) && rd_q;
    assign ls_sram_wr_en_o   = (state_q == WAIT) && wr_q;
    assign ls_sram_wr_data_o = wr_data_q;
    assign ls_sram_wr_mask_o = wr_mask_q;
    assign ls_sram_wr_size_o = size_q;
    assign ls_sram_rd_size_o = size_q;

    // the decoder must never ask for a load and a store at once.
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(rd_en_i && wr_en_i));

    // misaligned accesses are not supported.
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        req |-> ((addr_i[2:0] & align_mask) == 3'b000));

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ls_sram_rd_en_o || ls_sram_wr_en_o) && !ack |=>
            $stable(ls_sram_addr_o) && $stable(ls_sram_rd_en_o) &&
            $stable(ls_sram_wr_en_o) && $stable(ls_sram_rd_size_o) &&
            $stable(ls_sram_wr_mask_o) && $stable(ls_sram_wr_data_o));

endmodule

//--- logic/csr_file.sv
module csr_file #(
    parameter logic [ls_pkg::XLEN-1:0] MTVEC_RESET = '0
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [ls_pkg::XLEN-1:0]     pc_i,
    input  ls_pkg::instr_u              instr_i,
    input  logic [ls_pkg::XLEN-1:0]     csr_wr_data_i,
    input  logic                        trap_i,
    input  logic                        stall_n_i,
    output logic [ls_pkg::XLEN-1:0]     csr_data_o,
    output logic [ls_pkg::XLEN-1:0]     mtvec_o,
    output logic [ls_pkg::XLEN-1:0]     mepc_o
);
    import ls_pkg::*;

    logic [XLEN-1:0]    mstatus_q;
    logic [XLEN-1:0]    mtvec_q;
    logic [XLEN-1:0]    mepc_q;
    logic [XLEN-1:0]    mcause_q;
    logic [XLEN-1:0]    operand;
    logic [XLEN-1:0]    new_val;
    logic               op_ok;
    logic               csr_we;
    logic               trap_we;

    // immediate forms take the 5-bit uimm, zero extended.
    assign operand = instr_i.csr.funct3[2] ?
                     {{(XLEN-5){1'b0}}, instr_i.csr.rs1_uimm} : csr_wr_data_i;

    always_comb begin
        case (instr_i.csr.csr_addr)
            CSR_MSTATUS: csr_data_o = mstatus_q;
            CSR_MTVEC:   csr_data_o = mtvec_q;
            CSR_MEPC:    csr_data_o = mepc_q;
            CSR_MCAUSE:  csr_data_o = mcause_q;
            default:     csr_data_o = '0;
        endcase
    end

    always_comb begin
        op_ok   = 1'b1;
        new_val = operand;
        case (instr_i.csr.funct3)
            F3_CSRRW, F3_CSRRWI: new_val = operand;
            F3_CSRRS, F3_CSRRSI: new_val = csr_data_o | operand;
            F3_CSRRC, F3_CSRRCI: new_val = csr_data_o & ~operand;
            default:             op_ok   = 1'b0;   // ecall, ebreak and mret land here.
        endcase
    end

    // x0 or a zero uimm means the register is only read.
    assign csr_we = stall_n_i && !trap_i && op_ok &&
                    (instr_i.csr.opcode == OPC_SYSTEM) &&
                    (instr_i.csr.rs1_uimm != 5'd0);

    assign trap_we = stall_n_i && trap_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus_q <= '0;
            mtvec_q   <= MTVEC_RESET;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (trap_we) begin
            mepc_q   <= pc_i;
            mcause_q <= MCAUSE_TRAP;
        end else if (csr_we) begin
            case (instr_i.csr.csr_addr)
                CSR_MSTATUS: mstatus_q <= new_val;
                CSR_MTVEC:   mtvec_q   <= new_val;
                CSR_MEPC:    mepc_q    <= new_val;
                CSR_MCAUSE:  mcause_q  <= new_val;
                default: begin
                    mstatus_q <= mstatus_q;
                end
            endcase
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

    // a stalled pipeline must leave every machine register untouched.
    a_no_wr_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        !stall_n_i |=> $stable(mstatus_q) && $stable(mtvec_q) &&
                       $stable(mepc_q) && $stable(mcause_q));

endmodule

//--- ls_stage/ls_stage.sv
module ls_stage #(
    parameter logic [ls_pkg::XLEN-1:0] MTVEC_RESET = '0
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [ls_pkg::XLEN-1:0]     pc_i,
    input  logic [ls_pkg::XLEN-1:0]     alu_res_i,
    input  logic [ls_pkg::XLEN-1:0]     rs2_i,
    input  logic [ls_pkg::XLEN-1:0]     wb_data_i,
    input  ls_pkg::instr_u              instr_i,
    input  ls_pkg::instr_u              instr_last_i,
    input  logic                        trap_i,
    input  logic                        stall_n_i,

    output logic [ls_pkg::XLEN-1:0]     ls_res_o,
    output logic [ls_pkg::XLEN-1:0]     csr_data_o,
    output logic [ls_pkg::XLEN-1:0]     mtvec_o,
    output logic [ls_pkg::XLEN-1:0]     mepc_o,
    output logic                        ls_busy_o,

    output logic [ls_pkg::XLEN-1:0]     ls_sram_addr_o,
    output logic                        ls_sram_rd_en_o,
    output logic                        ls_sram_wr_en_o,
    output logic [ls_pkg::XLEN-1:0]     ls_sram_wr_data_o,
    output logic [7:0]                  ls_sram_wr_mask_o,
    output ls_pkg::mem_size_t           ls_sram_wr_size_o,
    output ls_pkg::mem_size_t           ls_sram_rd_size_o,
    input  logic                        ls_sram_rd_data_valid_i,
    input  logic                        ls_sram_wr_data_ok_i,
    input  logic [ls_pkg::XLEN-1:0]     ls_sram_rd_data_i
);
    import ls_pkg::*;

    logic               wr_en;
    logic               rd_en;
    mem_size_t          mem_op;
    logic [XLEN-1:0]    wr_data;    // store data after forwarding.

    ls_ctrl u_ls_ctrl (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .wr_en_o      (wr_en),
        .rd_en_o      (rd_en),
        .mem_op_o     (mem_op),
        .wr_data_o    (wr_data)
    );

    lsu u_lsu (
        .clk                     (clk),
        .rst_n_i                 (rst_n_i),
        .wr_en_i                 (wr_en),
        .rd_en_i                 (rd_en),
        .mem_op_i                (mem_op),
        .wr_data_i               (wr_data),
        .addr_i                  (alu_res_i),
        .ls_sram_rd_data_valid_i (ls_sram_rd_data_valid_i),
        .ls_sram_wr_data_ok_i    (ls_sram_wr_data_ok_i),
        .ls_sram_rd_data_i       (ls_sram_rd_data_i),
        .ls_res_o                (ls_res_o),
        .ls_busy_o               (ls_busy_o),
        .ls_sram_addr_o          (ls_sram_addr_o),
        .ls_sram_rd_en_o         (ls_sram_rd_en_o),
        .ls_sram_wr_en_o         (ls_sram_wr_en_o),
        .ls_sram_wr_data_o       (ls_sram_wr_data_o),
        .ls_sram_wr_mask_o       (ls_sram_wr_mask_o),
        .ls_sram_wr_size_o       (ls_sram_wr_size_o),
        .ls_sram_rd_size_o       (ls_sram_rd_size_o)
    );

    // the ALU result doubles as the CSR operand.
    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr_file (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .csr_wr_data_i (alu_res_i),
        .trap_i        (trap_i),
        .stall_n_i     (stall_n_i),
        .csr_data_o    (csr_data_o),
        .mtvec_o       (mtvec_o),
        .mepc_o        (mepc_o)
    );

endmodule

//--- verification/sram_model.sv
module sram_model (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        rd_en_i,
    input  logic                        wr_en_i,
    input  logic [ls_pkg::XLEN-1:0]     addr_i,
    input  logic [ls_pkg::XLEN-1:0]     wr_data_i,
    input  logic [7:0]                  wr_mask_i,
    output logic [ls_pkg::XLEN-1:0]     rd_data_o,
    output logic                        rd_data_valid_o,
    output logic                        wr_data_ok_o
);
    logic [63:0] mem [0:15];    // 128 bytes, word index from addr_i[6:3].
    logic [31:0] lfsr;
    int          delay;

    // Galois form, one step gives one random bit in the low bit.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    initial begin
        lfsr = 32'h8eda_a5e3;
        rd_data_o = '0;
        rd_data_valid_o = 1'b0;
        wr_data_ok_o = 1'b0;
        for (int a = 0; a < 128; a++) begin
            mem[a >> 3][8*(a % 8) +: 8] = 8'(a * 37) ^ 8'h5a ^ 8'(a >> 4);
        end
    end

    // requests are looked at just after the edge, once the enables have settled.
    always begin
        @(posedge clk);
        #1;
        rd_data_valid_o = 1'b0;
        wr_data_ok_o = 1'b0;
        if (rst_n_i && (rd_en_i || wr_en_i)) begin
            delay = 0;
            for (int b = 0; b < 3; b++) begin
                delay = delay | (int'(lfsr[0]) << b);
                lfsr = lfsr_step(lfsr);
            end
            for (int c = 0; c < delay && c < 8; c++) begin
                @(posedge clk);
                #1;
            end
            if (rd_en_i) begin
                rd_data_o = mem[addr_i[6:3]];
                rd_data_valid_o = 1'b1;
            end else begin
                for (int b = 0; b < 8; b++) begin
                    if (wr_mask_i[b]) mem[addr_i[6:3]][8*b +: 8] = wr_data_i[8*b +: 8];
                end
                wr_data_ok_o = 1'b1;
            end
        end
    end

endmodule

//--- verification/tb_ls_stage.sv
module tb_ls_stage;
    import ls_pkg::*;

    localparam logic [XLEN-1:0] MTVEC_INIT = 64'h0000_0000_8000_0100;

    logic clk = 1'b0;
    logic rst_n_i;
    logic [XLEN-1:0] pc_i, alu_res_i, rs2_i, wb_data_i;
    instr_u instr_i, instr_last_i;
    logic trap_i, stall_n_i;
    logic [XLEN-1:0] ls_res_o, csr_data_o, mtvec_o, mepc_o, sram_addr, sram_wdata, sram_rdata;
    logic ls_busy_o, sram_rd_en, sram_wr_en, sram_valid, sram_ok;
    logic [7:0] sram_mask;
    mem_size_t sram_wr_size, sram_rd_size;
    logic [7:0] exp_mem [0:127];    // each byte that memory should hold.
    logic [XLEN-1:0] mtvec_exp, mepc_exp, mcause_exp;
    int err_count = 0;
    int timeout_count = 0;

    always #20 clk = ~clk;

    ls_stage #(.MTVEC_RESET(MTVEC_INIT)) u_ls_stage (
        .clk(clk), .rst_n_i(rst_n_i), .pc_i(pc_i), .alu_res_i(alu_res_i), .rs2_i(rs2_i),
        .wb_data_i(wb_data_i), .instr_i(instr_i), .instr_last_i(instr_last_i),
        .trap_i(trap_i), .stall_n_i(stall_n_i), .ls_res_o(ls_res_o),
        .csr_data_o(csr_data_o), .mtvec_o(mtvec_o), .mepc_o(mepc_o), .ls_busy_o(ls_busy_o),
        .ls_sram_addr_o(sram_addr), .ls_sram_rd_en_o(sram_rd_en),
        .ls_sram_wr_en_o(sram_wr_en), .ls_sram_wr_data_o(sram_wdata),
        .ls_sram_wr_mask_o(sram_mask), .ls_sram_wr_size_o(sram_wr_size),
        .ls_sram_rd_size_o(sram_rd_size), .ls_sram_rd_data_valid_i(sram_valid),
        .ls_sram_wr_data_ok_i(sram_ok), .ls_sram_rd_data_i(sram_rdata)
    );

    sram_model u_sram (
        .clk(clk), .rst_n_i(rst_n_i), .rd_en_i(sram_rd_en), .wr_en_i(sram_wr_en),
        .addr_i(sram_addr), .wr_data_i(sram_wdata), .wr_mask_i(sram_mask),
        .rd_data_o(sram_rdata), .rd_data_valid_o(sram_valid), .wr_data_ok_o(sram_ok)
    );

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
            err_count++;
        end
    endtask

    task automatic check_mask(input logic [7:0] got, input logic [7:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
            err_count++;
        end
    endtask

    task automatic check_size(input mem_size_t got, input mem_size_t exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
            err_count++;
        end
    endtask

    function automatic instr_u mem_instr(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rs2, input logic [4:0] rd);
        instr_u i;
        i = '0;
        i.mem.opcode = opc;
        i.mem.funct3 = f3;
        i.mem.rs2 = rs2;
        i.mem.rd = rd;
        return i;
    endfunction

    function automatic logic [XLEN-1:0] load_expect(input int addr, input logic [2:0] f3);
        int n;
        logic [XLEN-1:0] v;
        n = 1 << f3[1:0];
        v = '0;
        for (int b = 0; b < n; b++) v[8*b +: 8] = exp_mem[addr + b];
        if (!f3[2] && n < 8 && v[8*n-1]) v = v | ~((64'd1 << (8 * n)) - 64'd1);
        return v;
    endfunction

    // runs one access and returns on the falling edge of the acknowledge cycle.
    task automatic run_access(input instr_u ins, input int addr, input logic [XLEN-1:0] data);
        int cycles;
        logic started;
        logic [XLEN-1:0] held_addr;
        logic [1:0] held_en;
        mem_size_t held_size;
        @(negedge clk);
        instr_i = ins;
        alu_res_i = XLEN'(addr);
        rs2_i = data;
        cycles = 0;
        started = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            if (started) begin
                check_word(sram_addr, held_addr, "address moved before acknowledge");
                check_size(sram_rd_size, held_size, "size moved before acknowledge");
                check_word(XLEN'({sram_rd_en, sram_wr_en}), XLEN'(held_en), "enables moved");
            end
            started = sram_rd_en || sram_wr_en;
            held_addr = sram_addr;
            held_size = sram_rd_size;
            held_en = {sram_rd_en, sram_wr_en};
        end while (ls_busy_o && cycles < 40);
        if (ls_busy_o) begin
            $display("Timeout: the access at address %0d never completed.", addr);
            timeout_count++;
        end else if (!(sram_valid || sram_ok)) begin
            $display("FAILED at %0t: busy fell before the SRAM answered", $time);
            err_count++;
        end
    endtask

    task automatic load_every_size();
        int n;
        int addr;
        logic [XLEN-1:0] exp;
        for (int f = 0; f < 7; f++) begin
            n = 1 << f[1:0];
            for (int off = 0; off < 8; off += n) begin
                addr = 8 * ((f * 5 + off) % 16) + off;
                exp = load_expect(addr, 3'(f));
                run_access(mem_instr(OPC_LOAD, 3'(f), 5'd0, 5'd7), addr, '0);
                check_word(ls_res_o, exp, "load result");
                check_size(sram_rd_size, 3'(f), "load size");
                check_word(sram_addr, XLEN'(addr), "load address");
                instr_i = '0;
                @(negedge clk);
                check_word(ls_res_o, exp, "registered load result");
            end
        end
    endtask

    task automatic store_every_size();
        int n;
        int addr;
        logic [XLEN-1:0] data;
        for (int s = 0; s < 4; s++) begin
            n = 1 << s;
            for (int off = 0; off < 8; off += n) begin
                addr = 8 * ((s * 3 + off) % 16) + off;
                data = 64'h0f1e_2d3c_4b5a_6978 ^ {48'h0, 8'(s), 8'(addr)};
                run_access(mem_instr(OPC_STORE, 3'(s), 5'd5, 5'd0), addr, data);
                check_mask(sram_mask, 8'((9'd1 << n) - 9'd1) << off, "store mask");
                check_word(sram_wdata, data << (8 * off), "store data");
                check_size(sram_wr_size, 3'(s), "store size");
                instr_i = '0;
                for (int b = 0; b < n; b++) exp_mem[addr + b] = data[8*b +: 8];
                addr = addr - off;
                run_access(mem_instr(OPC_LOAD, F3_D, 5'd0, 5'd7), addr, '0);
                check_word(ls_res_o, load_expect(addr, F3_D), "memory after store");
                instr_i = '0;
            end
        end
    endtask

    task automatic store_after(input instr_u last, input logic [4:0] rs2,
                               input logic [XLEN-1:0] exp, input string msg);
        instr_last_i = last;
        run_access(mem_instr(OPC_STORE, F3_D, rs2, 5'd0), 72, 64'h1111_2222_3333_4444);
        check_word(sram_wdata, exp, msg);
        instr_i = '0;
        for (int b = 0; b < 8; b++) exp_mem[72 + b] = exp[8*b +: 8];
        instr_last_i = '0;
    endtask

    task automatic forward_store_data();
        wb_data_i = 64'hfeed_face_cafe_beef;
        store_after(mem_instr(OPC_LOAD, F3_D, 5'd0, 5'd5), 5'd5, wb_data_i,
                    "forwarded store data");
        store_after(mem_instr(OPC_LOAD, F3_D, 5'd0, 5'd0), 5'd0, 64'h1111_2222_3333_4444,
                    "rd x0");
        store_after(mem_instr(OPC_LOAD, F3_D, 5'd0, 5'd6), 5'd5, 64'h1111_2222_3333_4444,
                    "other rd");
        store_after(mem_instr(OPC_STORE, F3_D, 5'd0, 5'd5), 5'd5, 64'h1111_2222_3333_4444,
                    "previous store");
    endtask

    // issues one CSR instruction and works out the written value from the funct3 rule.
    task automatic csr_op(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] rs1,
                          input logic [XLEN-1:0] opnd, inout logic [XLEN-1:0] shadow);
        instr_u ins;
        logic [XLEN-1:0] v;
        ins = '0;
        ins.csr.opcode = OPC_SYSTEM;
        ins.csr.funct3 = f3;
        ins.csr.csr_addr = addr;
        ins.csr.rs1_uimm = rs1;
        ins.csr.rd = 5'd1;
        @(negedge clk);
        instr_i = ins;
        alu_res_i = opnd;
        #5;
        check_word(csr_data_o, shadow, "CSR old value");
        v = f3[2] ? XLEN'(rs1) : opnd;
        if (rs1 != 5'd0) begin
            case (f3[1:0])
                2'b01:   shadow = v;
                2'b10:   shadow = shadow | v;
                default: shadow = shadow & ~v;
            endcase
        end
        @(negedge clk);
        instr_i = '0;
    endtask

    task automatic csr_read_modify_write();
        check_word(mtvec_o, MTVEC_INIT, "mtvec after reset");
        csr_op(F3_CSRRW, CSR_MTVEC, 5'd3, 64'h1000_0000_0000_0040, mtvec_exp);
        csr_op(F3_CSRRS, CSR_MTVEC, 5'd3, 64'h0f, mtvec_exp);
        csr_op(F3_CSRRC, CSR_MTVEC, 5'd3, 64'h03, mtvec_exp);
        csr_op(F3_CSRRS, CSR_MTVEC, 5'd0, 64'hff, mtvec_exp);   // x0 only reads.
        check_word(mtvec_o, mtvec_exp, "mtvec after register forms");
        csr_op(F3_CSRRWI, CSR_MTVEC, 5'h14, 64'hdead, mtvec_exp);
        csr_op(F3_CSRRSI, CSR_MTVEC, 5'h03, 64'hdead, mtvec_exp);
        csr_op(F3_CSRRCI, CSR_MTVEC, 5'h01, 64'hdead, mtvec_exp);
        check_word(mtvec_o, mtvec_exp, "mtvec after immediate forms");
        csr_op(F3_CSRRW, CSR_MEPC, 5'd9, 64'h0000_1234_5678_9abc, mepc_exp);
        csr_op(F3_CSRRCI, CSR_MEPC, 5'h0c, 64'h0, mepc_exp);
        check_word(mepc_o, mepc_exp, "mepc after CSR writes");
    endtask

    task automatic trap_and_stall();
        @(negedge clk);
        pc_i = 64'h0000_0000_8000_2468;
        trap_i = 1'b1;
        @(negedge clk);
        trap_i = 1'b0;
        mepc_exp = pc_i;
        check_word(mepc_o, mepc_exp, "mepc after trap");
        mcause_exp = MCAUSE_TRAP;
        csr_op(F3_CSRRS, CSR_MCAUSE, 5'd0, 64'h0, mcause_exp);
        stall_n_i = 1'b0;
        trap_i = 1'b1;
        pc_i = 64'h0000_0000_9000_0000;
        instr_i = '0;
        instr_i.csr.opcode = OPC_SYSTEM;
        instr_i.csr.funct3 = F3_CSRRW;
        instr_i.csr.csr_addr = CSR_MTVEC;
        instr_i.csr.rs1_uimm = 5'd4;
        alu_res_i = 64'h5555_5555;
        @(negedge clk);
        trap_i = 1'b0;    // the stalled CSR write is now presented without a trap.
        @(negedge clk);
        stall_n_i = 1'b1;
        instr_i = '0;
        check_word(mepc_o, mepc_exp, "mepc while stalled");
        check_word(mtvec_o, mtvec_exp, "mtvec while stalled");
    endtask

    initial begin
        rst_n_i = 1'b0;
        pc_i = '0;
        alu_res_i = '0;
        rs2_i = '0;
        wb_data_i = '0;
        instr_i = '0;
        instr_last_i = '0;
        trap_i = 1'b0;
        stall_n_i = 1'b1;
        mtvec_exp = MTVEC_INIT;
        mepc_exp = '0;
        for (int a = 0; a < 128; a++) exp_mem[a] = 8'(a * 37) ^ 8'h5a ^ 8'(a >> 4);
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;
        check_word(XLEN'({sram_rd_en, sram_wr_en, ls_busy_o}), '0, "idle after reset");
        load_every_size();
        store_every_size();
        forward_store_data();
        csr_read_modify_write();
        trap_and_stall();
        $display("errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- ls_stage.f
common/ls_pkg.sv
ls_stage/ls_ctrl.sv
ls_stage/lsu.sv
logic/csr_file.sv
ls_stage/ls_stage.sv
verification/sram_model.sv
verification/tb_ls_stage.sv

//--- Makefile
# Verilator build and run for the load/store stage testbench.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f ls_stage.f \
		--top-module tb_ls_stage -Mdir obj_dir -o Vtb_ls_stage
	./obj_dir/Vtb_ls_stage | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
